//--- verilog/mult_cfg.svh
// widths, stage count and register tag sizes for the multiply unit
// plus the zero register and the multiply function codes
`ifndef MULT_CFG_SVH
`define MULT_CFG_SVH

//////////////////////////////////////////////////
// datapath
`define XLEN          64                        // operand and result width
`define STAGE_BITS    16                        // multiplier bits per stage
`define NUM_STAGES    (`XLEN / `STAGE_BITS)     // 4 stages
`define MULT_LATENCY  (`NUM_STAGES + 1)         // issue reg + stages

//////////////////////////////////////////////////
// register tags
`define PR_IDX_W      7                         // physical reg tag
`define AR_IDX_W      5                         // architectural reg tag
`define ZERO_REG      5'd31                     // r31 always reads zero

//////////////////////////////////////////////////
// function field, instruction bits 11:5
`define FUNC_MULL     7'h00
`define FUNC_MULQ     7'h20

`endif

//--- verilog/mult_pkg.sv
// types shared by the multiply unit
// operand-B source select and the multiply opcode

package mult_pkg;

  // operand-B source, driven by the decoder along with the instruction
  // codes 2 and 3 are unused and give a zero operand
  typedef enum logic [1:0]
  {
    opb_is_regb    = 2'h0,  // register B value
    opb_is_alu_imm = 2'h1   // zero-extended 8-bit literal
  } opb_sel_e;

  // multiply flavour, decoded from the function field
  typedef enum logic
  {
    op_mulq = 1'b0,         // low 64 bits of the product
    op_mull = 1'b1          // low 32 bits, sign-extended
  } mult_op_e;

endpackage

//--- verilog/mult_operand_sel.sv
// issue register for one multiply lane
// operand-B mux, literal build and zero-register forcing

`timescale 1ns/10ps

`include "mult_cfg.svh"

module mult_operand_sel
  import mult_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 issue_valid,
  input  logic [31:0]          issue_ir,
  input  opb_sel_e             issue_opb_sel,
  input  logic [`XLEN-1:0]     issue_pra,
  input  logic [`XLEN-1:0]     issue_prb,
  input  logic [`PR_IDX_W-1:0] issue_dest_pr_idx,
  input  logic [`AR_IDX_W-1:0] issue_dest_ar_idx,
  output logic [`XLEN-1:0]     mcand,      // operand A
  output logic [`XLEN-1:0]     mplier,     // operand B
  output logic                 op_valid,
  output logic [6:0]           op_func,
  output logic [`PR_IDX_W-1:0] op_pr_idx,
  output logic [`AR_IDX_W-1:0] op_ar_idx
);

  logic                 valid_q;
  logic [31:0]          ir_q;
  opb_sel_e             opb_sel_q;
  logic [`XLEN-1:0]     pra_q;
  logic [`XLEN-1:0]     prb_q;
  logic [`PR_IDX_W-1:0] pr_idx_q;
  logic [`AR_IDX_W-1:0] ar_idx_q;
  logic                 ra_is_zero;
  logic                 rb_is_zero;
  logic [`XLEN-1:0]     alu_imm;

  //////////////////////////////////////////////////
  // issue register
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      valid_q   <= 1'b0;
      ir_q      <= '0;
      opb_sel_q <= opb_sel_e'(2'b00);
      pra_q     <= '0;
      prb_q     <= '0;
      pr_idx_q  <= '0;
      ar_idx_q  <= '0;
    end
    else
    begin
      valid_q   <= issue_valid;    // strobe, one per instruction
      ir_q      <= issue_ir;
      opb_sel_q <= issue_opb_sel;
      pra_q     <= issue_pra;
      prb_q     <= issue_prb;
      pr_idx_q  <= issue_dest_pr_idx;
      ar_idx_q  <= issue_dest_ar_idx;
    end
  end

  //////////////////////////////////////////////////
  // operand select
  assign ra_is_zero = (ir_q[25:21] == `ZERO_REG);  // ra field
  assign rb_is_zero = (ir_q[20:16] == `ZERO_REG);  // rb field
  assign alu_imm    = {{(`XLEN-8){1'b0}}, ir_q[20:13]};  // 8-bit literal

  assign mcand = ra_is_zero ? '0 : pra_q;

  always_comb
  begin
    case (opb_sel_q)
      opb_is_regb:    mplier = rb_is_zero ? '0 : prb_q;
      opb_is_alu_imm: mplier = alu_imm;
      default:        mplier = '0;             // undefined select
    endcase
  end

  // control side, straight from the register
  assign op_valid  = valid_q;
  assign op_func   = ir_q[11:5];
  assign op_pr_idx = pr_idx_q;
  assign op_ar_idx = ar_idx_q;

  // decoder must hand over a clean select with every instruction
  assert property (@(posedge clock) disable iff (reset)
    op_valid |-> !$isunknown(opb_sel_q))
    else $error("operand select unknown on a valid issue");

endmodule

//--- verilog/mult_stage.sv
// one partial-product stage of the pipelined multiplier
// consumes STAGE_BITS of the multiplier per cycle

`timescale 1ns/10ps

`include "mult_cfg.svh"

module mult_stage
(
  input  logic             clock,
  input  logic [`XLEN-1:0] product_in,   // running sum from previous stage
  input  logic [`XLEN-1:0] mplier_in,
  input  logic [`XLEN-1:0] mcand_in,
  output logic [`XLEN-1:0] product_out,
  output logic [`XLEN-1:0] mplier_out,
  output logic [`XLEN-1:0] mcand_out
);

  logic [`XLEN-1:0] prod_in_q;          // sum so far
  logic [`XLEN-1:0] partial_q;          // this stage's contribution
  logic [`XLEN-1:0] mplier_chunk;
  logic [`XLEN-1:0] partial_product;

  // low slice of the multiplier times the shifted multiplicand
  assign mplier_chunk    = {{(`XLEN-`STAGE_BITS){1'b0}}, mplier_in[`STAGE_BITS-1:0]};
  assign partial_product = mplier_chunk * mcand_in;   // only low XLEN bits kept

  // datapath only, no reset
  always_ff @(posedge clock)
  begin
    prod_in_q  <= product_in;
    partial_q  <= partial_product;
    mplier_out <= mplier_in >> `STAGE_BITS;   // next slice moves down
    mcand_out  <= mcand_in << `STAGE_BITS;    // weight moves up
  end

  // add sits after the registers, next stage registers the sum
  assign product_out = prod_in_q + partial_q;

endmodule

//--- verilog/mult_pipe.sv
// chain of multiplier stages with zero as the first product
// final mull sign extension after the last stage

`timescale 1ns/10ps

`include "mult_cfg.svh"

module mult_pipe
  import mult_pkg::*;
(
  input  logic             clock,
  input  logic [`XLEN-1:0] mcand,
  input  logic [`XLEN-1:0] mplier,
  input  mult_op_e         last_op,    // opcode aligned with last stage
  output logic [`XLEN-1:0] result
);

  // element g feeds stage g, element NUM_STAGES is the chain end
  logic [`XLEN-1:0] prod_chain   [`NUM_STAGES+1];
  logic [`XLEN-1:0] mplier_chain [`NUM_STAGES+1];
  logic [`XLEN-1:0] mcand_chain  [`NUM_STAGES+1];
  logic [`XLEN-1:0] product;

  assign prod_chain[0]   = '0;
  assign mplier_chain[0] = mplier;
  assign mcand_chain[0]  = mcand;

  //////////////////////////////////////////////////
  // stage chain
  for (genvar g = 0; g < `NUM_STAGES; g++)
  begin : g_stage
    mult_stage i_mult_stage
    (
      .clock       (clock),
      .product_in  (prod_chain[g]),
      .mplier_in   (mplier_chain[g]),
      .mcand_in    (mcand_chain[g]),
      .product_out (prod_chain[g+1]),
      .mplier_out  (mplier_chain[g+1]),
      .mcand_out   (mcand_chain[g+1])
    );
  end

  assign product = prod_chain[`NUM_STAGES];

  //////////////////////////////////////////////////
  // result format
  always_comb
  begin
    if (last_op == op_mull)
    begin
      // 32-bit result with the sign bit copied up
      result = {{(`XLEN/2){product[`XLEN/2-1]}}, product[`XLEN/2-1:0]};
    end
    else
    begin
      result = product;                      // mulq keeps the full low half
    end
  end

endmodule

//--- verilog/mult_ctrl.sv
// control for the multiply lane
// opcode decode and the valid/opcode/tag shift register that
// runs alongside the multiplier stages and drives completion

`timescale 1ns/10ps

`include "mult_cfg.svh"

module mult_ctrl
  import mult_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 op_valid,       // from the issue register
  input  logic [6:0]           op_func,
  input  logic [`PR_IDX_W-1:0] op_pr_idx,
  input  logic [`AR_IDX_W-1:0] op_ar_idx,
  output mult_op_e             last_op,        // to result formatting
  output logic                 complete,
  output logic [`PR_IDX_W-1:0] result_pr_idx,
  output logic [`AR_IDX_W-1:0] result_ar_idx
);

  mult_op_e                dec_op;
  logic [`NUM_STAGES-1:0]  valid_q;            // bit g matches stage g
  mult_op_e                op_q     [`NUM_STAGES];
  logic [`PR_IDX_W-1:0]    pr_idx_q [`NUM_STAGES];
  logic [`AR_IDX_W-1:0]    ar_idx_q [`NUM_STAGES];

  //////////////////////////////////////////////////
  // decode
  // anything but mull is treated as mulq
  always_comb
  begin
    if (op_func == `FUNC_MULL)
    begin
      dec_op = op_mull;
    end
    else
    begin
      dec_op = op_mulq;
    end
  end

  //////////////////////////////////////////////////
  // stage tracking
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      valid_q <= '0;                            // pipe empty
    end
    else
    begin
      valid_q <= {valid_q[`NUM_STAGES-2:0], op_valid};
    end
  end

  // opcode and tags move with the data, no reset
  always_ff @(posedge clock)
  begin
    op_q[0]     <= dec_op;
    pr_idx_q[0] <= op_pr_idx;
    ar_idx_q[0] <= op_ar_idx;
    for (int i = 1; i < `NUM_STAGES; i++)
    begin
      op_q[i]     <= op_q[i-1];
      pr_idx_q[i] <= pr_idx_q[i-1];
      ar_idx_q[i] <= ar_idx_q[i-1];
    end
  end

  // last entry lines up with the last stage registers
  assign last_op       = op_q[`NUM_STAGES-1];
  assign complete      = valid_q[`NUM_STAGES-1];   // one-cycle pulse
  assign result_pr_idx = pr_idx_q[`NUM_STAGES-1];
  assign result_ar_idx = ar_idx_q[`NUM_STAGES-1];

  //////////////////////////////////////////////////
  // checks
  // only the two multiply functions are ever routed to this lane
  assert property (@(posedge clock) disable iff (reset)
    op_valid |-> (op_func == `FUNC_MULL) || (op_func == `FUNC_MULQ))
    else $error("unsupported multiply function %h", op_func);

  // every completion traces back to an issue NUM_STAGES cycles earlier
  assert property (@(posedge clock) disable iff (reset)
    complete |-> $past(op_valid, `NUM_STAGES))
    else $error("completion without matching issue");

endmodule

//--- verilog/mult_unit.sv
// top of the integer multiply lane
// issue register/operand select, control tracking and multiplier pipe

`timescale 1ns/10ps

`include "mult_cfg.svh"

module mult_unit
  import mult_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 issue_valid,
  input  logic [31:0]          issue_ir,
  input  opb_sel_e             issue_opb_sel,
  input  logic [`XLEN-1:0]     issue_pra,
  input  logic [`XLEN-1:0]     issue_prb,
  input  logic [`PR_IDX_W-1:0] issue_dest_pr_idx,
  input  logic [`AR_IDX_W-1:0] issue_dest_ar_idx,
  output logic                 complete,
  output logic [`XLEN-1:0]     result,
  output logic [`PR_IDX_W-1:0] result_pr_idx,
  output logic [`AR_IDX_W-1:0] result_ar_idx
);

  logic [`XLEN-1:0]     mcand;
  logic [`XLEN-1:0]     mplier;
  logic                 op_valid;
  logic [6:0]           op_func;
  logic [`PR_IDX_W-1:0] op_pr_idx;
  logic [`AR_IDX_W-1:0] op_ar_idx;
  mult_op_e             last_op;

  // issue register, operands out to the pipe
  mult_operand_sel i_mult_operand_sel
  (
    .clock             (clock),
    .reset             (reset),
    .issue_valid       (issue_valid),
    .issue_ir          (issue_ir),
    .issue_opb_sel     (issue_opb_sel),
    .issue_pra         (issue_pra),
    .issue_prb         (issue_prb),
    .issue_dest_pr_idx (issue_dest_pr_idx),
    .issue_dest_ar_idx (issue_dest_ar_idx),
    .mcand             (mcand),
    .mplier            (mplier),
    .op_valid          (op_valid),
    .op_func           (op_func),
    .op_pr_idx         (op_pr_idx),
    .op_ar_idx         (op_ar_idx)
  );

  mult_ctrl i_mult_ctrl
  (
    .clock         (clock),
    .reset         (reset),
    .op_valid      (op_valid),
    .op_func       (op_func),
    .op_pr_idx     (op_pr_idx),
    .op_ar_idx     (op_ar_idx),
    .last_op       (last_op),
    .complete      (complete),
    .result_pr_idx (result_pr_idx),
    .result_ar_idx (result_ar_idx)
  );

  mult_pipe i_mult_pipe
  (
    .clock   (clock),
    .mcand   (mcand),
    .mplier  (mplier),
    .last_op (last_op),
    .result  (result)
  );

endmodule

//--- verification/mult_ref.svh
// reference model for the multiply lane, built from the operand rules
// and the value compare used by the checker
`ifndef MULT_REF_SVH
`define MULT_REF_SVH

`include "mult_cfg.svh"

//////////////////////////////////////////////////
// expected result of one issued instruction
function automatic logic [`XLEN-1:0] expected_product
(
  input logic [31:0]      ir,
  input opb_sel_e         sel,
  input logic [`XLEN-1:0] pra,
  input logic [`XLEN-1:0] prb
);
  logic [`XLEN-1:0]   a;
  logic [`XLEN-1:0]   b;
  logic [2*`XLEN-1:0] full;   // double-width product, low half is kept
  a = (ir[25:21] == 5'd31) ? '0 : pra;                       // r31 reads zero
  case (sel)
    opb_is_regb:    b = (ir[20:16] == 5'd31) ? '0 : prb;
    opb_is_alu_imm: b = {{(`XLEN-8){1'b0}}, ir[20:13]};      // literal, no sign
    default:        b = '0;
  endcase
  full = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
  if (ir[11:5] == `FUNC_MULL)
  begin
    return {{(`XLEN/2){full[`XLEN/2-1]}}, full[`XLEN/2-1:0]};   // longword form
  end
  return full[`XLEN-1:0];
endfunction

//////////////////////////////////////////////////
// single compare, mismatch stops the run
task automatic compare_value
(
  input string            name,
  input logic [`XLEN-1:0] actual,
  input logic [`XLEN-1:0] expected
);
  if (actual !== expected)
  begin
    report_failure($sformatf("ERR %s got 0x%h expected 0x%h", name, actual, expected));
  end
endtask

`endif

//--- verification/mult_unit_tb.sv
// testbench for the multiply lane
// random and directed issue, expected-result queue, in-order checker, watchdog

`timescale 1ns/10ps

`include "mult_cfg.svh"

module mult_unit_tb
  import mult_pkg::*;
;

  localparam int N_MULQ     = 40;
  localparam int N_LIT      = 20;
  localparam int N_UNDEF    = 4;
  localparam int N_ZERO     = 4;
  localparam int N_MULL_DIR = 4;
  localparam int N_MULL     = 20;
  localparam int N_STREAM   = 80;
  localparam int TEST_COUNT = N_MULQ + N_LIT + N_UNDEF + N_ZERO + N_MULL_DIR + N_MULL + N_STREAM;

  typedef struct packed
  {
    logic [`XLEN-1:0]     result;
    logic [`PR_IDX_W-1:0] pr_idx;
    logic [`AR_IDX_W-1:0] ar_idx;
    logic [31:0]          cycle;      // cycle the issue was presented
  } exp_entry_t;

  logic                 clock;
  logic                 reset;
  logic                 issue_valid;
  logic [31:0]          issue_ir;
  opb_sel_e             issue_opb_sel;
  logic [`XLEN-1:0]     issue_pra;
  logic [`XLEN-1:0]     issue_prb;
  logic [`PR_IDX_W-1:0] issue_dest_pr_idx;
  logic [`AR_IDX_W-1:0] issue_dest_ar_idx;
  logic                 complete;
  logic [`XLEN-1:0]     result;
  logic [`PR_IDX_W-1:0] result_pr_idx;
  logic [`AR_IDX_W-1:0] result_ar_idx;

  int                   seed;
  int unsigned          cycle_count = 0;
  exp_entry_t           exp_q[$];     // oldest outstanding first

  mult_unit i_mult_unit
  (
    .clock             (clock),
    .reset             (reset),
    .issue_valid       (issue_valid),
    .issue_ir          (issue_ir),
    .issue_opb_sel     (issue_opb_sel),
    .issue_pra         (issue_pra),
    .issue_prb         (issue_prb),
    .issue_dest_pr_idx (issue_dest_pr_idx),
    .issue_dest_ar_idx (issue_dest_ar_idx),
    .complete          (complete),
    .result            (result),
    .result_pr_idx     (result_pr_idx),
    .result_ar_idx     (result_ar_idx)
  );

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;   // 20 ns period
  end

  always @(posedge clock)
  begin
    cycle_count <= cycle_count + 1;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  `include "mult_ref.svh"

  //////////////////////////////////////////////////
  // instruction words in the Alpha operate format
  function automatic logic [31:0] reg_form_ir
  (
    input logic [4:0] ra,
    input logic [4:0] rb,
    input logic [6:0] func,
    input logic [4:0] rc
  );
    return {6'h13, ra, rb, 3'b000, 1'b0, func, rc};
  endfunction

  function automatic logic [31:0] lit_form_ir
  (
    input logic [4:0] ra,
    input logic [7:0] lit,
    input logic [6:0] func,
    input logic [4:0] rc
  );
    return {6'h13, ra, lit, 1'b1, func, rc};   // bit 12 marks the literal
  endfunction

  //////////////////////////////////////////////////
  // stimulus
  task automatic drive_issue
  (
    input logic [31:0]          ir,
    input opb_sel_e             sel,
    input logic [`XLEN-1:0]     pra,
    input logic [`XLEN-1:0]     prb,
    input logic [`PR_IDX_W-1:0] pr,
    input logic [`AR_IDX_W-1:0] ar
  );
    @(posedge clock);
    issue_valid       <= 1'b1;
    issue_ir          <= ir;
    issue_opb_sel     <= sel;
    issue_pra         <= pra;
    issue_prb         <= prb;
    issue_dest_pr_idx <= pr;
    issue_dest_ar_idx <= ar;
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge clock);
      issue_valid <= 1'b0;
    end
  endtask

  task automatic drain_pipe();
    go_idle(1);
    while (exp_q.size() != 0)
    begin
      @(posedge clock);
    end
  endtask

  task automatic random_issue(input opb_sel_e sel, input logic [6:0] func);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] ir;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    r4 = $random(seed);   // fields and tags
    if (sel == opb_is_alu_imm)
    begin
      ir = lit_form_ir(r4[4:0], r4[17:10], func, r4[29:25]);
    end
    else
    begin
      ir = reg_form_ir(r4[4:0], r4[9:5], func, r4[29:25]);
    end
    drive_issue(ir, sel, {r0, r1}, {r2, r3}, r4[24:18], r4[29:25]);
  endtask

  // mixed ops with gaps of 0 to 3 idle cycles
  task automatic stream_issue();
    logic [31:0] r;
    opb_sel_e    sel;
    logic [6:0]  func;
    r    = $random(seed);
    func = r[0] ? `FUNC_MULL : `FUNC_MULQ;
    if (r[3:1] < 3'd5)
    begin
      sel = opb_is_regb;
    end
    else if (r[3:1] < 3'd7)
    begin
      sel = opb_is_alu_imm;
    end
    else
    begin
      sel = opb_sel_e'({1'b1, r[4]});   // undefined code 2 or 3
    end
    random_issue(sel, func);
    go_idle(int'(r[6:5]));
  endtask

  //////////////////////////////////////////////////
  // checker and expected queue sampled mid-cycle
  always @(negedge clock)
  begin : check_and_record
    exp_entry_t entry;
    if (complete === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        report_failure("completion arrived with no instruction outstanding");
      end
      else
      begin
        entry = exp_q.pop_front();
        compare_value("result", result, entry.result);
        compare_value("result_pr_idx", `XLEN'(result_pr_idx), `XLEN'(entry.pr_idx));
        compare_value("result_ar_idx", `XLEN'(result_ar_idx), `XLEN'(entry.ar_idx));
        compare_value("latency", `XLEN'(cycle_count - entry.cycle), `XLEN'(`MULT_LATENCY));
      end
    end
    else if (complete !== 1'b0)
    begin
      report_failure("complete output is unknown");
    end
    // new issue goes in after the pop so the order stays fixed
    if (!reset && issue_valid)
    begin
      entry.result = expected_product(issue_ir, issue_opb_sel, issue_pra, issue_prb);
      entry.pr_idx = issue_dest_pr_idx;
      entry.ar_idx = issue_dest_ar_idx;
      entry.cycle  = cycle_count;
      exp_q.push_back(entry);
    end
  end

  // watchdog
  initial
  begin
    repeat (TEST_COUNT * 10 + 100) @(posedge clock);
    $display("watchdog expired, the run took longer than the tests allow");
    $display("=== FAIL ===");
    $fatal(1);
  end

  //////////////////////////////////////////////////
  // test sequence
  initial
  begin
    seed              = 92355;
    reset             = 1'b1;
    issue_valid       = 1'b0;
    issue_ir          = '0;
    issue_opb_sel     = opb_is_regb;
    issue_pra         = '0;
    issue_prb         = '0;
    issue_dest_pr_idx = '0;
    issue_dest_ar_idx = '0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    go_idle(20);                                     // quiet pipe with no completions

    repeat (N_MULQ) random_issue(opb_is_regb, `FUNC_MULQ);
    drain_pipe();

    repeat (N_LIT) random_issue(opb_is_alu_imm, `FUNC_MULQ);
    repeat (N_UNDEF / 2) random_issue(opb_sel_e'(2'd2), `FUNC_MULQ);
    repeat (N_UNDEF / 2) random_issue(opb_sel_e'(2'd3), `FUNC_MULQ);
    drain_pipe();

    // r31 sources with nonzero junk in the register values
    drive_issue(reg_form_ir(5'd31, 5'd4, `FUNC_MULQ, 5'd1), opb_is_regb,
                64'hdead_beef_0123_4567, 64'h5, 7'h11, 5'd1);
    drive_issue(reg_form_ir(5'd2, 5'd31, `FUNC_MULQ, 5'd2), opb_is_regb,
                64'h7, 64'hffff_0000_ffff_0000, 7'h12, 5'd2);
    drive_issue(reg_form_ir(5'd31, 5'd31, `FUNC_MULL, 5'd3), opb_is_regb,
                64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321, 7'h13, 5'd3);
    drive_issue(lit_form_ir(5'd6, 8'hf8, `FUNC_MULQ, 5'd4), opb_is_alu_imm,
                64'h3, 64'hffff_ffff_ffff_ffff, 7'h14, 5'd4);  // rb bits read 31 but literal kept
    drain_pipe();

    // mull around the bit 31 boundary
    drive_issue(reg_form_ir(5'd1, 5'd2, `FUNC_MULL, 5'd5), opb_is_regb,
                64'h1_0000, 64'h8000, 7'h21, 5'd5);        // 0x8000_0000 is negative
    drive_issue(reg_form_ir(5'd1, 5'd2, `FUNC_MULL, 5'd6), opb_is_regb,
                64'h1234, 64'h10, 7'h22, 5'd6);
    drive_issue(reg_form_ir(5'd1, 5'd2, `FUNC_MULL, 5'd7), opb_is_regb,
                64'hffff_ffff_ffff_ffff, 64'h2, 7'h23, 5'd7);
    drive_issue(reg_form_ir(5'd1, 5'd2, `FUNC_MULL, 5'd8), opb_is_regb,
                64'h7fff_ffff, 64'h1, 7'h24, 5'd8);
    repeat (N_MULL) random_issue(opb_is_regb, `FUNC_MULL);
    drain_pipe();

    repeat (N_STREAM) stream_issue();
    drain_pipe();
    go_idle(10);

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- all.f
+incdir+verilog
+incdir+verification
verilog/mult_pkg.sv
verilog/mult_operand_sel.sv
verilog/mult_stage.sv
verilog/mult_pipe.sv
verilog/mult_ctrl.sv
verilog/mult_unit.sv
verification/mult_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=mult_unit_tb_sim

verilator --binary --timing --assert \
  -f all.f \
  --top-module mult_unit_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

echo "simulation finished cleanly"
exit 0
